// ==== common/lsu_pkg.sv ====
//////////////////////////////
// lsu package
// widths, access type codes and the bus structs of the load/store unit
//////////////////////////////

package lsu_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int unsigned ADDR_W = 32;  // byte address
  localparam int unsigned DATA_W = 32;  // one bus word
  localparam int unsigned BE_W   = 4;   // byte lanes per word

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;
  typedef logic [1:0]        offset_t;    // byte offset within a word
  typedef logic [1:0]        lsu_type_t;  // access size

  // access size codes, 2'd3 is treated as a byte too
  localparam lsu_type_t TYPE_WORD = 2'd0;
  localparam lsu_type_t TYPE_HALF = 2'd1;
  localparam lsu_type_t TYPE_BYTE = 2'd2;

  //////////////////////////////
  // structs
  //////////////////////////////

  // request from the execute stage, held until the access is done
  typedef struct packed {
    logic      we;        // store when set
    lsu_type_t acc_type;  // word, half word or byte
    logic      sign_ext;  // sign extend load data
    data_t     wdata;     // store data, lsb aligned
  } lsu_req_t;

  // control fields captured on each grant
  typedef struct packed {
    offset_t   offset;
    lsu_type_t acc_type;
    logic      sign_ext;
    logic      we;
  } lsu_ctrl_t;

  // bus command, address always word aligned
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } mem_req_t;

  // bus answer
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    logic  err;     // only valid with rvalid
    data_t rdata;
  } mem_rsp_t;

endpackage

// ==== lsu/lsu_store_align.sv ====
//////////////////////////////
// store aligner
// byte enables and store data rotation for the current beat
//////////////////////////////

module lsu_store_align import lsu_pkg::*; (
  input  lsu_req_t req_i,
  input  addr_t    addr_i,
  input  logic     second_part_i,   // high for the upper word of a split access
  output be_t      be_o,
  output data_t    wdata_o
);

  offset_t offset;

  assign offset = addr_i[1:0];

  //////////////////////////////
  // byte enables
  //////////////////////////////

  always_comb begin
    unique case (req_i.acc_type)
      TYPE_WORD: begin
        if (!second_part_i) begin
          unique case (offset)  // lanes from the offset upward
            2'b00:   be_o = 4'b1111;
            2'b01:   be_o = 4'b1110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end else begin
          unique case (offset)  // remaining lanes below the offset
            2'b01:   be_o = 4'b0001;
            2'b10:   be_o = 4'b0011;
            2'b11:   be_o = 4'b0111;
            default: be_o = 4'b0000;  // aligned word never has a second part
          endcase
        end
      end

      TYPE_HALF: begin
        if (!second_part_i) begin
          unique case (offset)
            2'b00:   be_o = 4'b0011;
            2'b01:   be_o = 4'b0110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;  // upper byte follows in lane 0
          endcase
        end else begin
          be_o = 4'b0001;
        end
      end

      default: be_o = be_t'(4'b0001 << offset);  // byte, code 2 or 3
    endcase
  end

  //////////////////////////////
  // data rotation
  //////////////////////////////

  // rotate left by offset bytes, the same word feeds both beats
  always_comb begin
    unique case (offset)
      2'b00:   wdata_o = req_i.wdata;
      2'b01:   wdata_o = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   wdata_o = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_o = {req_i.wdata[7:0],  req_i.wdata[31:8]};
    endcase
  end

endmodule

// ==== lsu/lsu_load_align.sv ====
//////////////////////////////
// load aligner
// merges split words and extracts half words and bytes
// with zero or sign extension
//////////////////////////////

module lsu_load_align import lsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  data_t     rdata_i,          // bus read data
  input  logic      rdata_update_i,   // first part of a split load arrives
  input  lsu_ctrl_t ctrl_i,
  output data_t     rdata_o
);

  logic [23:0] rdata_q;   // upper three bytes of the first word
  data_t       rdata_w;   // realigned word
  logic [15:0] half_sel;
  logic [7:0]  byte_sel;
  data_t       rdata_h;
  data_t       rdata_b;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rdata_update_i) begin
      rdata_q <= rdata_i[31:8];
    end
  end

  //////////////////////////////
  // word merge
  //////////////////////////////

  // low bytes come from the held first word, high bytes from the second
  always_comb begin
    unique case (ctrl_i.offset)
      2'b00:   rdata_w = rdata_i;
      2'b01:   rdata_w = {rdata_i[7:0],  rdata_q[23:0]};
      2'b10:   rdata_w = {rdata_i[15:0], rdata_q[23:8]};
      default: rdata_w = {rdata_i[23:0], rdata_q[23:16]};
    endcase
  end

  //////////////////////////////
  // half word and byte select
  //////////////////////////////

  always_comb begin
    unique case (ctrl_i.offset)
      2'b00:   half_sel = rdata_i[15:0];
      2'b01:   half_sel = rdata_i[23:8];
      2'b10:   half_sel = rdata_i[31:16];
      default: half_sel = {rdata_i[7:0], rdata_q[23:16]};  // crosses into next word
    endcase
  end

  assign byte_sel = rdata_i[8*ctrl_i.offset +: 8];

  // extend to a full word
  assign rdata_h = ctrl_i.sign_ext ? {{16{half_sel[15]}}, half_sel} : {16'h0000, half_sel};
  assign rdata_b = ctrl_i.sign_ext ? {{24{byte_sel[7]}}, byte_sel} : {24'h00_0000, byte_sel};

  always_comb begin
    unique case (ctrl_i.acc_type)
      TYPE_WORD: rdata_o = rdata_w;
      TYPE_HALF: rdata_o = rdata_h;
      default:   rdata_o = rdata_b;   // byte, code 2 or 3
    endcase
  end

endmodule

// ==== lsu/lsu_ctrl.sv ====
//////////////////////////////
// load/store access controller
// req/gnt/rvalid FSM with split handling, control and
// last address registers, response and error outputs
//////////////////////////////

module lsu_ctrl import lsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      lsu_req_i,
  input  lsu_req_t  req_i,
  input  addr_t     addr_i,
  input  mem_rsp_t  mem_rsp_i,

  output logic      data_req_o,
  output logic      addr_incr_req_o,    // ask execute stage for addr + 4
  output logic      second_part_o,
  output lsu_ctrl_t ctrl_q_o,
  output logic      rdata_update_o,     // one cycle strobe
  output logic      lsu_req_done_o,
  output logic      lsu_resp_valid_o,
  output logic      lsu_rdata_valid_o,
  output logic      load_err_o,
  output logic      store_err_o,
  output addr_t     addr_last_o,
  output logic      busy_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,               // first grant of a split access pending
    WAIT_RVALID_MIS,            // second part out, first rvalid pending
    WAIT_GNT,                   // last grant pending
    WAIT_RVALID_MIS_GNTS_DONE   // both granted, first rvalid pending
  } ls_fsm_e;

  ls_fsm_e   fsm_cs, fsm_ns;
  logic      split_access;
  logic      second_part_q, second_part_d;
  logic      lsu_err_q, lsu_err_d;   // error of the first part
  logic      ctrl_update;
  logic      addr_update;
  logic      any_err;
  lsu_ctrl_t ctrl_q, ctrl_d;
  addr_t     addr_last_q;
  offset_t   data_offset;

  assign data_offset = addr_i[1:0];

  // misaligned words and half words crossing the word boundary need two beats
  assign split_access = ((req_i.acc_type == TYPE_WORD) && (data_offset != 2'b00)) ||
                        ((req_i.acc_type == TYPE_HALF) && (data_offset == 2'b11));

  assign ctrl_d = '{offset:   data_offset,
                    acc_type: req_i.acc_type,
                    sign_ext: req_i.sign_ext,
                    we:       req_i.we};

  //////////////////////////////
  // access FSM
  //////////////////////////////

  always_comb begin
    fsm_ns          = fsm_cs;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    second_part_d   = second_part_q;
    lsu_err_d       = lsu_err_q;
    ctrl_update     = 1'b0;
    addr_update     = 1'b0;
    rdata_update_o  = 1'b0;

    unique case (fsm_cs)
      IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;  // fresh access
          if (mem_rsp_i.gnt) begin
            ctrl_update   = 1'b1;
            addr_update   = 1'b1;
            second_part_d = split_access;
            fsm_ns        = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            fsm_ns        = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (mem_rsp_i.gnt) begin
          ctrl_update   = 1'b1;
          addr_update   = 1'b1;
          second_part_d = 1'b1;
          fsm_ns        = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1;  // second part goes out already
        addr_incr_req_o = 1'b1;
        if (mem_rsp_i.rvalid) begin
          lsu_err_d      = mem_rsp_i.err;
          rdata_update_o = ~ctrl_q.we;
          // keep first failing address for the trap value
          addr_update    = mem_rsp_i.gnt & ~mem_rsp_i.err;
          second_part_d  = ~mem_rsp_i.gnt;
          fsm_ns         = mem_rsp_i.gnt ? IDLE : WAIT_GNT;
        end else if (mem_rsp_i.gnt) begin
          second_part_d = 1'b0;
          fsm_ns        = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = second_part_q;
        if (mem_rsp_i.gnt) begin
          ctrl_update   = 1'b1;
          addr_update   = ~lsu_err_q;
          second_part_d = 1'b0;
          fsm_ns        = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_req_o = 1'b1;  // second address still needed for addr_last
        if (mem_rsp_i.rvalid) begin
          lsu_err_d      = mem_rsp_i.err;
          addr_update    = ~mem_rsp_i.err;
          rdata_update_o = ~ctrl_q.we;
          fsm_ns         = IDLE;
        end
      end

      default: fsm_ns = IDLE;
    endcase
  end

  // done in the cycle the last grant is taken
  assign lsu_req_done_o = (lsu_req_i | (fsm_cs != IDLE)) & (fsm_ns == IDLE);

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_cs        <= IDLE;
      second_part_q <= 1'b0;
      lsu_err_q     <= 1'b0;
    end else begin
      fsm_cs        <= fsm_ns;
      second_part_q <= second_part_d;
      lsu_err_q     <= lsu_err_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q <= '0;
    end else if (ctrl_update) begin
      ctrl_q <= ctrl_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= addr_i;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  // last rvalid always lands with the FSM back in idle
  assign lsu_resp_valid_o  = mem_rsp_i.rvalid & (fsm_cs == IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~ctrl_q.we;

  assign any_err     = lsu_err_q | mem_rsp_i.err;  // either part failed
  assign load_err_o  = any_err & ~ctrl_q.we & lsu_resp_valid_o;
  assign store_err_o = any_err &  ctrl_q.we & lsu_resp_valid_o;

  assign second_part_o = second_part_q;
  assign ctrl_q_o      = ctrl_q;
  assign addr_last_o   = addr_last_q;
  assign busy_o        = (fsm_cs != IDLE);

endmodule

// ==== lsu/lsu_top.sv ====
//////////////////////////////
// load/store unit top
// joins the access FSM with the store and load aligners and
// builds the word wide bus command
//////////////////////////////

module lsu_top import lsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // execute stage side
  input  logic      lsu_req_i,          // level, held until done
  input  lsu_req_t  req_i,
  input  addr_t     addr_i,             // first address, or first + 4 on incr request
  output logic      lsu_req_done_o,
  output logic      addr_incr_req_o,
  output logic      lsu_resp_valid_o,
  output logic      lsu_rdata_valid_o,
  output data_t     lsu_rdata_o,
  output logic      load_err_o,
  output logic      store_err_o,
  output addr_t     addr_last_o,        // trap value source
  output logic      busy_o,

  // data bus
  output logic      data_req_o,
  output mem_req_t  mem_req_o,
  input  mem_rsp_t  mem_rsp_i
);

  logic      second_part;   // second half of a split access
  logic      rdata_update;  // capture first part of a split load
  lsu_ctrl_t ctrl_q;
  be_t       data_be;
  data_t     data_wdata;

  lsu_ctrl lsu_ctrl_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .req_i             (req_i),
    .addr_i            (addr_i),
    .mem_rsp_i         (mem_rsp_i),
    .data_req_o        (data_req_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .second_part_o     (second_part),
    .ctrl_q_o          (ctrl_q),
    .rdata_update_o    (rdata_update),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .addr_last_o       (addr_last_o),
    .busy_o            (busy_o)
  );

  lsu_store_align lsu_store_align_i (
    .req_i         (req_i),
    .addr_i        (addr_i),
    .second_part_i (second_part),
    .be_o          (data_be),
    .wdata_o       (data_wdata)
  );

  lsu_load_align lsu_load_align_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rdata_i        (mem_rsp_i.rdata),
    .rdata_update_i (rdata_update),
    .ctrl_i         (ctrl_q),
    .rdata_o        (lsu_rdata_o)
  );

  // bus command, low address bits are carried by the byte enables
  assign mem_req_o.addr  = {addr_i[ADDR_W-1:2], 2'b00};
  assign mem_req_o.we    = req_i.we;
  assign mem_req_o.be    = data_be;
  assign mem_req_o.wdata = data_wdata;

endmodule

// ==== dv/lsu_mem_model.sv ====
//////////////////////////////
// bus memory model
// 256 byte memory behind req/gnt/rvalid with random delays,
// addresses with ERR_BIT set answer with err
//////////////////////////////

module lsu_mem_model import lsu_pkg::*; #(
  parameter int unsigned ERR_BIT = 7,
  parameter int unsigned SEED    = 32'h1
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     data_req_i,
  input  mem_req_t mem_req_i,
  output mem_rsp_t mem_rsp_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0]  mem [256];
  integer      seed;
  int unsigned wait_q;        // cycles the open request has waited
  int unsigned gnt_delay_q;   // wait needed before the next grant
  int unsigned cycle;         // local cycle count
  int unsigned due;
  int unsigned last_due;      // keeps answers in order, one per cycle
  logic [7:0]  idx;
  logic        acc_err;
  data_t       word;
  logic        gnt;
  logic        rvalid_q, err_q;
  data_t       rdata_q;

  // answers still owed, oldest first
  int unsigned q_due [$];
  logic        q_err [$];
  data_t       q_rdata [$];

  assign gnt              = data_req_i & (wait_q >= gnt_delay_q);
  assign mem_rsp_o.gnt    = gnt;
  assign mem_rsp_o.rvalid = rvalid_q;
  assign mem_rsp_o.err    = err_q;
  assign mem_rsp_o.rdata  = rdata_q;

  initial begin
    seed = SEED;
    for (int i = 0; i < 256; i++)
      mem[i] = 8'(i * 37 + 11);   // fill touches every address bit
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q      <= 0;
      gnt_delay_q <= 0;
      rvalid_q    <= 1'b0;
      err_q       <= 1'b0;
      rdata_q     <= '0;
      cycle       = 0;
      last_due    = 0;
      q_due.delete();
      q_err.delete();
      q_rdata.delete();
    end else begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      if (data_req_i && gnt) begin
        acc_err = mem_req_i.addr[ERR_BIT];
        for (int j = 0; j < 4; j++) begin
          idx = {mem_req_i.addr[7:2], 2'(j)};
          word[8*j +: 8] = mem[idx];              // read before the write
          if (mem_req_i.we && mem_req_i.be[j] && !acc_err)
            mem[idx] = mem_req_i.wdata[8*j +: 8];
        end
        due = cycle + ({$random(seed)} % 3);      // rvalid 1 to 3 cycles on
        if (due <= last_due)
          due = last_due + 1;
        last_due = due;
        q_due.push_back(due);
        q_err.push_back(acc_err);
        q_rdata.push_back(word);
        wait_q      <= 0;
        gnt_delay_q <= {$random(seed)} % 3;       // next grant after 0 to 2 cycles
      end else if (data_req_i) begin
        wait_q <= wait_q + 1;
      end
      if ((q_due.size() > 0) && (q_due[0] <= cycle)) begin
        rvalid_q <= 1'b1;
        err_q    <= q_err.pop_front();
        rdata_q  <= q_rdata.pop_front();
        void'(q_due.pop_front());
      end
      cycle = cycle + 1;
    end
  end

endmodule

// ==== dv/lsu_tb.sv ====
//////////////////////////////
// load/store unit testbench
// directed and random accesses checked against a reference byte array
//////////////////////////////

module lsu_tb import lsu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned ERR_BIT        = 7;            // error region select
  localparam int unsigned SEED           = 32'ha9bc2c9b;
  localparam int unsigned NUM_ACCESSES   = 80;           // all tests together
  localparam int unsigned ACCESS_CYCLES  = 40;           // worst case per access
  localparam int unsigned TIMEOUT_CYCLES = NUM_ACCESSES * ACCESS_CYCLES * 5 / 4;

  logic        clk;
  logic        rst_n;
  logic        lsu_req;
  lsu_req_t    req;
  addr_t       base_addr;
  addr_t       addr;
  logic        req_done, addr_incr_req, resp_valid, rdata_valid;
  data_t       rdata;
  logic        load_err, store_err, busy, data_req;
  addr_t       addr_last;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  integer      seed = SEED;
  logic [7:0]  ref_mem [256];
  int unsigned cycle_cnt, grant_cnt, resp_cnt;

  // execute stage hands out the next word address on request
  assign addr = addr_incr_req ? base_addr + 32'd4 : base_addr;

  lsu_top lsu_top_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .lsu_req_i         (lsu_req),
    .req_i             (req),
    .addr_i            (addr),
    .lsu_req_done_o    (req_done),
    .addr_incr_req_o   (addr_incr_req),
    .lsu_resp_valid_o  (resp_valid),
    .lsu_rdata_valid_o (rdata_valid),
    .lsu_rdata_o       (rdata),
    .load_err_o        (load_err),
    .store_err_o       (store_err),
    .addr_last_o       (addr_last),
    .busy_o            (busy),
    .data_req_o        (data_req),
    .mem_req_o         (mem_req),
    .mem_rsp_i         (mem_rsp)
  );

  lsu_mem_model #(.ERR_BIT(ERR_BIT), .SEED(SEED)) lsu_mem_model_i (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .data_req_i (data_req),
    .mem_req_i  (mem_req),
    .mem_rsp_o  (mem_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // bus event counters and hang guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (data_req && mem_rsp.gnt)
      grant_cnt <= grant_cnt + 1;
    if (resp_valid)
      resp_cnt <= resp_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Test failed");
      $fatal(1, "run hung, no end after %0d cycles", cycle_cnt);
    end
  end

  task automatic check_value(input data_t actual, input data_t expected, input string what);
    if (actual !== expected) begin
      $display("Fail %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic int unsigned size_bytes(input lsu_type_t t);
    if (t == TYPE_WORD)
      return 4;
    if (t == TYPE_HALF)
      return 2;
    return 1;   // codes 2 and 3
  endfunction

  // addressed bytes from the reference extended to a word
  function automatic data_t ref_load(input lsu_type_t t, input logic sx, input addr_t a);
    data_t w;
    for (int k = 0; k < 4; k++)
      w[8*k +: 8] = ref_mem[8'(a + k)];
    if (t == TYPE_WORD)
      return w;
    if (t == TYPE_HALF)
      return sx ? {{16{w[15]}}, w[15:0]} : {16'h0000, w[15:0]};
    return sx ? {{24{w[7]}}, w[7:0]} : {24'h00_0000, w[7:0]};
  endfunction

  //////////////////////////////
  // one access end to end
  //////////////////////////////

  task automatic run_access(input logic we, input lsu_type_t t, input logic sx,
                            input addr_t a, input data_t wd);
    int unsigned n;
    int unsigned grants_before;
    int unsigned resps_before;
    logic        split;
    logic        err_first, err_second;
    addr_t       a2;
    addr_t       ba;
    data_t       exp_rdata;
    n          = size_bytes(t);
    split      = (a[1:0] + n) > 4;   // crosses into the next word
    a2         = a + 32'd4;
    err_first  = a[ERR_BIT];
    err_second = split & a2[ERR_BIT];
    exp_rdata  = ref_load(t, sx, a);
    grants_before = grant_cnt;
    resps_before  = resp_cnt;
    base_addr <= a;
    req       <= '{we: we, acc_type: t, sign_ext: sx, wdata: wd};
    lsu_req   <= 1'b1;
    do
      @(posedge clk);
    while (!req_done);
    lsu_req <= 1'b0;
    do
      @(posedge clk);
    while (!resp_valid);
    check_value(grant_cnt - grants_before, split ? 2 : 1, "bus grants per access");
    check_value(resp_cnt - resps_before, 0, "early response");
    check_value(rdata_valid, !we, "rdata valid");
    check_value(load_err, !we && (err_first || err_second), "load error");
    check_value(store_err, we && (err_first || err_second), "store error");
    if (err_first || err_second)
      check_value(addr_last, err_first ? a : a2, "trap address");
    else if (!we)
      check_value(rdata, exp_rdata, "load data");
    if (we) begin
      for (int k = 0; k < n; k++) begin
        ba = a + k;
        if (!ba[ERR_BIT])
          ref_mem[ba[7:0]] = wd[8*k +: 8];   // failed lanes keep old data
      end
    end
    @(posedge clk);                 // one idle cycle between accesses
    check_value(busy, 1'b0, "busy after response");
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic reset_and_word_access();
    check_value(busy, 1'b0, "busy after reset");
    check_value(data_req, 1'b0, "bus request after reset");
    run_access(1'b1, TYPE_WORD, 1'b0, 32'h10, 32'hdead_beef);
    run_access(1'b0, TYPE_WORD, 1'b0, 32'h10, '0);
  endtask

  task automatic sub_word_loads();
    run_access(1'b1, TYPE_WORD, 1'b0, 32'h20, 32'h80ff_7f81);  // mixed sign bits
    for (int off = 0; off < 4; off++) begin
      run_access(1'b0, TYPE_BYTE, 1'b0, 32'h20 + off, '0);
      run_access(1'b0, TYPE_BYTE, 1'b1, 32'h20 + off, '0);
      if (off < 3) begin
        run_access(1'b0, TYPE_HALF, 1'b0, 32'h20 + off, '0);
        run_access(1'b0, TYPE_HALF, 1'b1, 32'h20 + off, '0);
      end
    end
  endtask

  task automatic split_accesses();
    for (int off = 1; off < 4; off++) begin
      run_access(1'b1, TYPE_WORD, 1'b0, 32'h30 + 9 * off, 32'hc3a5_0f5a + off);
      run_access(1'b0, TYPE_WORD, 1'b0, 32'h30 + 9 * off, '0);
    end
    run_access(1'b1, TYPE_HALF, 1'b0, 32'h5b, 32'h0000_b7e1);
    run_access(1'b0, TYPE_HALF, 1'b0, 32'h5b, '0);
    run_access(1'b0, TYPE_HALF, 1'b1, 32'h5b, '0);
  endtask

  task automatic partial_stores();
    run_access(1'b1, TYPE_WORD, 1'b0, 32'h60, 32'h1122_3344);
    run_access(1'b1, TYPE_BYTE, 1'b0, 32'h61, 32'hffff_ffa5);  // upper bits must not land
    run_access(1'b1, TYPE_HALF, 1'b0, 32'h62, 32'hdead_beef);
    run_access(1'b0, TYPE_WORD, 1'b0, 32'h60, '0);
  endtask

  task automatic bus_errors();
    run_access(1'b0, TYPE_WORD, 1'b0, 32'h84, '0);            // first part fails
    run_access(1'b1, TYPE_BYTE, 1'b0, 32'h9a, 32'h55);
    run_access(1'b0, TYPE_WORD, 1'b1, 32'h7e, '0);            // only second part fails
    run_access(1'b1, TYPE_HALF, 1'b0, 32'h7f, 32'h1234);
    run_access(1'b0, TYPE_WORD, 1'b0, 32'hbe, '0);            // both parts fail
    run_access(1'b1, TYPE_WORD, 1'b0, 32'hfd, 32'h0bad_cafe); // second part wraps to 0x100
    run_access(1'b0, TYPE_WORD, 1'b0, 32'h7c, '0);
  endtask

  task automatic random_accesses();
    logic [31:0] rnd;
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      run_access(rnd[0], lsu_type_t'(rnd[2:1]), rnd[3], {25'h0, rnd[14:8]}, $random(seed));
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    lsu_req   = 1'b0;
    req       = '0;
    base_addr = '0;
    for (int i = 0; i < 256; i++)
      ref_mem[i] = 8'(i * 37 + 11);   // matches the model's power-up fill
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    reset_and_word_access();
    sub_word_loads();
    split_accesses();
    partial_stores();
    bus_errors();
    random_accesses();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== lsu.f ====
common/lsu_pkg.sv
lsu/lsu_store_align.sv
lsu/lsu_load_align.sv
lsu/lsu_ctrl.sv
lsu/lsu_top.sv
dv/lsu_mem_model.sv
dv/lsu_tb.sv
